//--- source/tag_pkg.sv
package tag_pkg;

    // Smaller tag means older instruction
    typedef logic [7:0] tag_t;

    typedef logic [6:0] preg_t;

    typedef struct packed {
        tag_t tag;                          // Tag of the store being retired
    } commit_t;

endpackage

//--- source/mem_pkg.sv
package mem_pkg;

    import tag_pkg::*;

    // Same encoding as funct3[1:0]
    typedef enum logic [1:0] {
        SZ_BYTE = 2'd0,
        SZ_HALF = 2'd1,
        SZ_WORD = 2'd2
    } size_t;

    typedef enum logic {
        EXT_ZERO = 1'b0,
        EXT_SIGN = 1'b1
    } sign_t;

    typedef enum logic [1:0] {
        LD_MISS    = 2'd0,
        LD_PARTIAL = 2'd1,
        LD_HIT     = 2'd2
    } ld_status_t;

    typedef struct packed {
        logic        is_store;
        logic [2:0]  funct3;
        logic [31:0] addr;
        logic [31:0] data;
        tag_t        tag;
        preg_t       preg;
    } mem_req_t;

    typedef struct packed {
        logic [29:0] waddr;
        logic [3:0]  mask;                  // Bytes touched within the word
        logic [1:0]  offset;
        size_t       size;
        sign_t       sign;
        logic        is_store;
        logic [31:0] data;                  // Store data already in its lanes
        tag_t        tag;
        preg_t       preg;
    } access_t;

    typedef struct packed {
        logic [31:0] data;
        ld_status_t  status;
        tag_t        tag;
        preg_t       preg;
        logic        is_store;
    } ld_resp_t;

    typedef struct packed {
        logic [29:0] waddr;
        logic [31:0] data;
        logic [3:0]  mask;
    } mem_wr_t;

endpackage

//--- source/lsu_decode.sv
module lsu_decode import mem_pkg::*; (
    input  logic     req_valid,
    input  mem_req_t req,
    output logic     acc_valid,
    output access_t  acc
);

    logic [3:0] base_mask;
    logic [1:0] offset;

    assign offset    = req.addr[1:0];
    assign acc_valid = req_valid;

    always_comb begin
        acc          = '0;
        acc.waddr    = req.addr[31:2];
        acc.offset   = offset;
        acc.is_store = req.is_store;
        acc.tag      = req.tag;
        acc.preg     = req.preg;
        acc.sign     = req.funct3[2] ? EXT_ZERO : EXT_SIGN; // LBU/LHU are unsigned

        case (req.funct3[1:0])
            2'b00: begin
                acc.size  = SZ_BYTE;
                base_mask = 4'b0001;
            end
            2'b01: begin
                acc.size  = SZ_HALF;
                base_mask = 4'b0011;
            end
            default: begin
                acc.size  = SZ_WORD;
                base_mask = 4'b1111;
            end
        endcase

        acc.mask = base_mask << offset;
        acc.data = req.data << {offset, 3'b000}; // Move low bytes into their lanes
    end

endmodule

//--- source/store_buffer.sv
module store_buffer import tag_pkg::*, mem_pkg::*; #(
    parameter int ENTRIES = 8
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        flush,
    input  logic        acc_valid,
    input  access_t     acc,
    input  logic        commit_valid,
    input  commit_t     commit,
    output logic        fwd_valid,
    output access_t     fwd,
    output logic [31:0] fwd_data,
    output logic [3:0]  fwd_mask,
    output logic        wr_valid,
    output mem_wr_t     wr,
    output logic        full
);

    localparam int IDX_W = $clog2(ENTRIES);

    typedef struct packed {
        tag_t        tag;
        logic [29:0] waddr;
        logic [31:0] data;
        logic [3:0]  mask;
    } entry_t;

    entry_t             ent [ENTRIES];
    logic [ENTRIES-1:0] ent_valid;
    logic [ENTRIES-1:0] next_valid;

    logic               store_accept;
    logic [IDX_W-1:0]   free_idx;
    logic               cm_found;
    logic [IDX_W-1:0]   cm_idx;
    logic               ld_found;
    logic [IDX_W-1:0]   ld_idx;

    assign store_accept = acc_valid && acc.is_store && !full; // Stores while full are dropped

    // Lowest free slot
    always_comb begin
        free_idx = '0;
        for (int i = ENTRIES - 1; i >= 0; i--) begin
            if (!ent_valid[i]) begin
                free_idx = IDX_W'(i);
            end
        end
    end

    always_comb begin
        cm_found = 1'b0;
        cm_idx   = '0;
        for (int i = ENTRIES - 1; i >= 0; i--) begin
            if (ent_valid[i] && ent[i].tag == commit.tag) begin
                cm_found = 1'b1;
                cm_idx   = IDX_W'(i);
            end
        end
    end

    // Youngest store to the same word that is still older than the load
    always_comb begin
        ld_found = 1'b0;
        ld_idx   = '0;
        for (int i = 0; i < ENTRIES; i++) begin
            if (ent_valid[i] && ent[i].waddr == acc.waddr && ent[i].tag < acc.tag &&
                (!ld_found || ent[i].tag > ent[ld_idx].tag)) begin
                ld_found = 1'b1;
                ld_idx   = IDX_W'(i);
            end
        end
    end

    always_comb begin
        next_valid = ent_valid;
        if (commit_valid && cm_found) begin
            next_valid[cm_idx] = 1'b0;
        end
        if (store_accept) begin
            next_valid[free_idx] = 1'b1; // Never the slot being drained
        end
    end

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            ent_valid <= '0;
            full      <= 1'b0;
            fwd_valid <= 1'b0;
            wr_valid  <= 1'b0;
        end else begin
            ent_valid <= next_valid;
            full      <= &next_valid;
            fwd_valid <= acc_valid;
            wr_valid  <= commit_valid && cm_found;
        end
    end

    always_ff @(posedge clk) begin
        if (store_accept) begin
            ent[free_idx] <= '{tag: acc.tag, waddr: acc.waddr, data: acc.data, mask: acc.mask};
        end

        fwd      <= acc;
        fwd_data <= ld_found ? ent[ld_idx].data : '0;
        if (ld_found && !acc.is_store) begin
            fwd_mask <= ent[ld_idx].mask & acc.mask; // Only bytes the load asks for
        end else begin
            fwd_mask <= 4'b0000;
        end

        wr <= '{waddr: ent[cm_idx].waddr, data: ent[cm_idx].data, mask: ent[cm_idx].mask};
    end

endmodule

//--- source/load_format.sv
module load_format import mem_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        flush,
    input  logic        fwd_valid,
    input  access_t     fwd,
    input  logic [31:0] fwd_data,
    input  logic [3:0]  fwd_mask,
    output logic        resp_valid,
    output ld_resp_t    resp
);

    logic [31:0] masked;
    logic [31:0] shifted;
    logic [31:0] ext;
    ld_status_t  status;
    ld_resp_t    next_resp;

    always_comb begin
        for (int b = 0; b < 4; b++) begin
            masked[8*b +: 8] = fwd_mask[b] ? fwd_data[8*b +: 8] : 8'h00; // Unfound bytes read as zero
        end
        shifted = masked >> {fwd.offset, 3'b000};

        case (fwd.size)
            SZ_BYTE: ext = (fwd.sign == EXT_SIGN) ? {{24{shifted[7]}}, shifted[7:0]}
                                                  : {24'h000000, shifted[7:0]};
            SZ_HALF: ext = (fwd.sign == EXT_SIGN) ? {{16{shifted[15]}}, shifted[15:0]}
                                                  : {16'h0000, shifted[15:0]};
            default: ext = shifted;
        endcase

        if (fwd.is_store || fwd_mask == 4'b0000) begin
            status = LD_MISS;
        end else if (fwd_mask == fwd.mask) begin
            status = LD_HIT;
        end else begin
            status = LD_PARTIAL;
        end

        next_resp.data     = (status == LD_MISS) ? 32'h0 : ext;
        next_resp.status   = status;
        next_resp.tag      = fwd.tag;
        next_resp.preg     = fwd.preg;
        next_resp.is_store = fwd.is_store;
    end

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            resp_valid <= 1'b0;
        end else begin
            resp_valid <= fwd_valid;
        end
    end

    always_ff @(posedge clk) begin
        resp <= next_resp;
    end

endmodule

//--- source/lsu_top.sv
module lsu_top import tag_pkg::*, mem_pkg::*; #(
    parameter int ENTRIES = 8
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     flush,
    input  logic     req_valid,
    input  mem_req_t req,
    input  logic     commit_valid,
    input  commit_t  commit,
    output logic     resp_valid,
    output ld_resp_t resp,
    output logic     wr_valid,
    output mem_wr_t  wr,
    output logic     full
);

    logic        acc_valid;
    access_t     acc;
    logic        fwd_valid;
    access_t     fwd;
    logic [31:0] fwd_data;
    logic [3:0]  fwd_mask;

    lsu_decode u_decode (
        .req_valid (req_valid),
        .req       (req),
        .acc_valid (acc_valid),
        .acc       (acc)
    );

    store_buffer #(
        .ENTRIES (ENTRIES)
    ) u_store_buffer (
        .clk          (clk),
        .rst          (rst),
        .flush        (flush),
        .acc_valid    (acc_valid),
        .acc          (acc),
        .commit_valid (commit_valid),
        .commit       (commit),
        .fwd_valid    (fwd_valid),
        .fwd          (fwd),
        .fwd_data     (fwd_data),
        .fwd_mask     (fwd_mask),
        .wr_valid     (wr_valid),
        .wr           (wr),
        .full         (full)
    );

    load_format u_load_format (
        .clk        (clk),
        .rst        (rst),
        .flush      (flush),
        .fwd_valid  (fwd_valid),
        .fwd        (fwd),
        .fwd_data   (fwd_data),
        .fwd_mask   (fwd_mask),
        .resp_valid (resp_valid),
        .resp       (resp)
    );

endmodule

//--- tests/tb_clock.sv
module tb_clock (
    output logic clk
);

    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        clk = 1'b0;
    end

    always #50 clk = ~clk; // 100 ns period

endmodule

//--- tests/lsu_chk.sv
module lsu_chk import tag_pkg::*, mem_pkg::*; (
    input logic    clk,
    input logic    rst,
    input logic    flush,
    input logic    acc_valid,
    input access_t acc,
    input logic    commit_valid,
    input logic    wr_valid,
    input logic    full
);

    timeunit 1ns;
    timeprecision 1ps;

    // A write is always the echo of a commit one cycle earlier
    a_wr_after_commit: assert property (@(posedge clk) disable iff (rst)
        wr_valid |-> $past(commit_valid))
        else $error("write port strobe without a commit in the previous cycle");

    a_full_stable: assert property (@(posedge clk) disable iff (rst)
        (!acc_valid && !commit_valid && !flush) |=> $stable(full))
        else $error("full changed with no request and no commit");

    // Dropped store leaves the buffer full
    a_drop_keeps_full: assert property (@(posedge clk) disable iff (rst)
        (acc_valid && acc.is_store && full && !commit_valid && !flush) |=> full)
        else $error("store while full changed occupancy");

endmodule

bind store_buffer lsu_chk u_chk (
    .clk          (clk),
    .rst          (rst),
    .flush        (flush),
    .acc_valid    (acc_valid),
    .acc          (acc),
    .commit_valid (commit_valid),
    .wr_valid     (wr_valid),
    .full         (full)
);

//--- tests/lsu_tb.sv
module lsu_tb import tag_pkg::*, mem_pkg::*;;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int ENTRIES = 8;

    typedef enum logic [1:0] {A_REQ, A_COMMIT, A_FLUSH} act_t;

    typedef struct packed {
        act_t     act;
        mem_req_t req;
        commit_t  cm;
        logic     exp_resp_v;
        ld_resp_t exp_resp;
        logic     exp_wr_v;
        mem_wr_t  exp_wr;
        logic     exp_full;
    } step_t;

    logic     clk;
    logic     rst;
    logic     flush;
    logic     req_valid;
    mem_req_t req;
    logic     commit_valid;
    commit_t  commit;
    logic     resp_valid;
    ld_resp_t resp;
    logic     wr_valid;
    mem_wr_t  wr;
    logic     full;

    step_t       steps[$];
    integer      seed = 70;
    int          cycles = 0;
    int          limit = 1000;

    // Reference view of the buffer
    logic        m_valid [ENTRIES];
    tag_t        m_tag   [ENTRIES];
    logic [29:0] m_waddr [ENTRIES];
    logic [31:0] m_data  [ENTRIES];
    logic [3:0]  m_mask  [ENTRIES];

    tb_clock u_clock (.clk(clk));

    lsu_top #(.ENTRIES(ENTRIES)) uut (
        .clk(clk), .rst(rst), .flush(flush),
        .req_valid(req_valid), .req(req),
        .commit_valid(commit_valid), .commit(commit),
        .resp_valid(resp_valid), .resp(resp),
        .wr_valid(wr_valid), .wr(wr), .full(full)
    );

    function automatic int occupancy();
        int n;
        n = 0;
        for (int i = 0; i < ENTRIES; i++) begin
            if (m_valid[i]) n++;
        end
        return n;
    endfunction

    function automatic logic [3:0] lane_mask(logic [2:0] funct3, logic [1:0] off);
        logic [3:0] m;
        m = (funct3[1:0] == 2'b00) ? 4'b0001 : (funct3[1:0] == 2'b01) ? 4'b0011 : 4'b1111;
        return m << off;
    endfunction

    task automatic add_store(logic [31:0] addr, logic [2:0] funct3, tag_t tag);
        step_t s;
        int    slot;
        s = '0;
        s.act = A_REQ;
        s.req = '{is_store: 1'b1, funct3: funct3, addr: addr, data: $random(seed),
                  tag: tag, preg: 7'd0};
        slot = -1;
        for (int i = ENTRIES - 1; i >= 0; i--) begin
            if (!m_valid[i]) slot = i;
        end
        if (slot >= 0) begin // Full buffer drops the store
            m_valid[slot] = 1'b1;
            m_tag[slot]   = tag;
            m_waddr[slot] = addr[31:2];
            m_data[slot]  = s.req.data << (8 * addr[1:0]);
            m_mask[slot]  = lane_mask(funct3, addr[1:0]);
        end
        s.exp_resp_v = 1'b1;
        s.exp_resp   = '{data: 32'h0, status: LD_MISS, tag: tag, preg: 7'd0, is_store: 1'b1};
        s.exp_full   = (occupancy() == ENTRIES);
        steps.push_back(s);
    endtask

    task automatic add_load(logic [31:0] addr, logic [2:0] funct3, tag_t tag, preg_t preg);
        step_t       s;
        int          best;
        logic [3:0]  lmask;
        logic [3:0]  fmask;
        logic [31:0] word;
        logic [31:0] val;
        s = '0;
        s.act = A_REQ;
        s.req = '{is_store: 1'b0, funct3: funct3, addr: addr, data: 32'h0, tag: tag, preg: preg};
        lmask = lane_mask(funct3, addr[1:0]);
        best = -1;
        for (int i = 0; i < ENTRIES; i++) begin
            if (m_valid[i] && m_waddr[i] == addr[31:2] && m_tag[i] < tag &&
                (best < 0 || m_tag[i] > m_tag[best])) best = i;
        end
        fmask = (best >= 0) ? (m_mask[best] & lmask) : 4'b0000;
        word = '0;
        for (int b = 0; b < 4; b++) begin
            if (fmask[b]) word[8*b +: 8] = m_data[best][8*b +: 8];
        end
        val = word >> (8 * addr[1:0]);
        if (funct3[1:0] == 2'b00) val = funct3[2] ? {24'h0, val[7:0]} : {{24{val[7]}}, val[7:0]};
        if (funct3[1:0] == 2'b01) val = funct3[2] ? {16'h0, val[15:0]} : {{16{val[15]}}, val[15:0]};
        s.exp_resp_v      = 1'b1;
        s.exp_resp.tag    = tag;
        s.exp_resp.preg   = preg;
        s.exp_resp.status = (fmask == 4'b0000) ? LD_MISS : (fmask == lmask) ? LD_HIT : LD_PARTIAL;
        s.exp_resp.data   = (fmask == 4'b0000) ? 32'h0 : val;
        s.exp_full        = (occupancy() == ENTRIES);
        steps.push_back(s);
    endtask

    task automatic add_commit(tag_t tag);
        step_t s;
        s = '0;
        s.act    = A_COMMIT;
        s.cm.tag = tag;
        for (int i = 0; i < ENTRIES; i++) begin
            if (m_valid[i] && m_tag[i] == tag) begin
                s.exp_wr_v = 1'b1;
                s.exp_wr   = '{waddr: m_waddr[i], data: m_data[i], mask: m_mask[i]};
                m_valid[i] = 1'b0;
            end
        end
        s.exp_full = (occupancy() == ENTRIES);
        steps.push_back(s);
    endtask

    task automatic add_flush();
        step_t s;
        s = '0;
        s.act = A_FLUSH;
        for (int i = 0; i < ENTRIES; i++) m_valid[i] = 1'b0;
        steps.push_back(s);
    endtask

    task automatic stop_run(string msg);
        $display("%s", msg);
        $display("Some tests failed");
        $fatal(1);
    endtask

    task automatic check_resp(logic got_v, ld_resp_t got, logic exp_v, ld_resp_t exp, int idx);
        if (got_v !== exp_v || (exp_v && got !== exp)) begin
            stop_run($sformatf("Error at %0t: step %0d response valid %b %p, expected %b %p",
                               $time, idx, got_v, got, exp_v, exp));
        end
    endtask

    task automatic check_wr(logic got_v, mem_wr_t got, logic exp_v, mem_wr_t exp, int idx);
        if (got_v !== exp_v || (exp_v && got !== exp)) begin
            stop_run($sformatf("Error at %0t: step %0d write valid %b %p, expected %b %p",
                               $time, idx, got_v, got, exp_v, exp));
        end
    endtask

    task automatic check_full(logic got, logic exp, int idx);
        if (got !== exp) begin
            stop_run($sformatf("Error at %0t: step %0d full is %b, expected %b",
                               $time, idx, got, exp));
        end
    endtask

    always @(posedge clk) begin
        cycles++;
        if (cycles > limit) begin
            stop_run("Timeout: the test sequence did not finish in time");
        end
    end

    initial begin
        rst          = 1'b1;
        flush        = 1'b0;
        req_valid    = 1'b0;
        req          = '0;
        commit_valid = 1'b0;
        commit       = '0;
        for (int i = 0; i < ENTRIES; i++) m_valid[i] = 1'b0;

        // Word store, then every load width and offset
        add_store(32'h100, 3'b010, 8'd10);
        add_load(32'h100, 3'b010, 8'd20, 7'd1);
        for (int o = 0; o < 4; o += 2) begin
            add_load(32'h100 + o, 3'b001, 8'd20, 7'd2);
            add_load(32'h100 + o, 3'b101, 8'd20, 7'd3);
        end
        for (int o = 0; o < 4; o++) begin
            add_load(32'h100 + o, 3'b000, 8'd20, 7'd4);
            add_load(32'h100 + o, 3'b100, 8'd20, 7'd5);
        end
        add_store(32'h205, 3'b000, 8'd11); // Partial overlap
        add_load(32'h204, 3'b010, 8'd21, 7'd6);
        add_load(32'h300, 3'b010, 8'd21, 7'd7);
        add_store(32'h400, 3'b010, 8'd12); // Two stores to one word
        add_store(32'h400, 3'b010, 8'd14);
        add_load(32'h400, 3'b010, 8'd30, 7'd8);
        add_load(32'h400, 3'b010, 8'd13, 7'd9);
        add_load(32'h400, 3'b010, 8'd5, 7'd10);
        add_commit(8'd10);
        add_load(32'h100, 3'b010, 8'd40, 7'd11);
        for (int i = 0; i < 5; i++) add_store(32'h500 + 4 * i, 3'b010, tag_t'(50 + i));
        add_store(32'h600, 3'b010, 8'd60); // Dropped
        add_load(32'h600, 3'b010, 8'd61, 7'd12);
        add_commit(8'd50);
        add_commit(8'd11); // Byte store drains in lane 1
        add_store(32'h700, 3'b010, 8'd62);
        add_store(32'h704, 3'b010, 8'd63);
        add_flush();
        add_load(32'h400, 3'b010, 8'd70, 7'd13);
        add_commit(8'd12);
        limit = 10 + 3 * steps.size() + 50;

        repeat (10) @(posedge clk);
        #1 rst = 1'b0;

        foreach (steps[i]) begin
            @(posedge clk);
            #1;
            req_valid    = (steps[i].act == A_REQ);
            req          = steps[i].req;
            commit_valid = (steps[i].act == A_COMMIT);
            commit       = steps[i].cm;
            flush        = (steps[i].act == A_FLUSH);
            @(posedge clk);
            #1;
            req_valid    = 1'b0;
            commit_valid = 1'b0;
            flush        = 1'b0;
            check_wr(wr_valid, wr, steps[i].exp_wr_v, steps[i].exp_wr, i);
            @(posedge clk);
            #1;
            check_resp(resp_valid, resp, steps[i].exp_resp_v, steps[i].exp_resp, i);
            check_full(full, steps[i].exp_full, i);
        end

        $display("All tests passed");
        $finish;
    end

endmodule

//--- files.f
source/tag_pkg.sv
source/mem_pkg.sv
source/lsu_decode.sv
source/store_buffer.sv
source/load_format.sv
source/lsu_top.sv
tests/tb_clock.sv
tests/lsu_chk.sv
tests/lsu_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= lsu_tb
RTL_TOP   ?= lsu_top
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

$(OBJ_DIR)/V$(TOP): $(shell cat $(FILELIST))
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

sim: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -q "All tests passed"

clean:
	rm -rf $(OBJ_DIR)
